// File: bg_settings.svh
`ifndef BG_SETTINGS_SVH
`define BG_SETTINGS_SVH

// Last visible column and line of the 1024x768 screen
`define BG_H_LAST 12'd1023
`define BG_V_LAST 12'd767

// Play arena, inner edges in pixels
`define BG_ARENA_TOP    317
`define BG_ARENA_BOTTOM 617
`define BG_ARENA_LEFT   361
`define BG_ARENA_RIGHT  661

// Frame thickness around the arena
`define BG_ARENA_BORDER 10

// 12-bit colours, 4 bits per channel as r_g_b
`define BG_RGB_BLACK  12'h0_0_0
`define BG_RGB_WHITE  12'hf_f_f
`define BG_RGB_YELLOW 12'hf_f_0
`define BG_RGB_RED    12'hf_0_0
`define BG_RGB_GREEN  12'h0_f_0
`define BG_RGB_BLUE   12'h0_0_f

`endif

// File: bg_pkg.sv
package bg_pkg;

    // Pixel counter, wide enough for the full frame including blanking
    typedef logic [11:0] coord_t;

    // Colour word
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // One pixel of video timing, 28 bits
    typedef struct packed {
        coord_t vcount;
        logic   vsync;
        logic   vblnk;
        coord_t hcount;
        logic   hsync;
        logic   hblnk;
    } vga_timing_t;

    // Screen selected by the game controller
    // Codes 2 to 7 may arrive but are not drawn here
    typedef enum logic [2:0] {
        MODE_MENU = 3'd0,
        MODE_GAME = 3'd1
    } bg_mode_t;

endpackage

// File: screen_frame_painter.sv
`timescale 1ns/1ps
`include "bg_settings.svh"

module screen_frame_painter
    import bg_pkg::*;
(
    input  vga_timing_t timing_in,
    output logic        edge_hit,
    output rgb_t        edge_rgb
);

    coord_t hcount;
    coord_t vcount;

    assign hcount = timing_in.hcount;
    assign vcount = timing_in.vcount;

    // Lines take priority over columns, so corners follow the line colour
    always_comb begin
        edge_hit = 1'b1;
        if (vcount == 12'd0) begin
            edge_rgb = `BG_RGB_YELLOW;
        end else if (vcount == `BG_V_LAST) begin
            edge_rgb = `BG_RGB_RED;
        end else if (hcount == 12'd0) begin
            edge_rgb = `BG_RGB_GREEN;
        end else if (hcount == `BG_H_LAST) begin
            edge_rgb = `BG_RGB_BLUE;
        end else begin
            // Not on any edge
            edge_hit = 1'b0;
            edge_rgb = `BG_RGB_BLACK;
        end
    end

endmodule

// File: menu_title_painter.sv
`timescale 1ns/1ps
`include "bg_settings.svh"

module menu_title_painter
    import bg_pkg::*;
(
    input  vga_timing_t timing_in,
    output logic        title_hit
);

    // Rectangle with an excluded low bound and an included high bound
    typedef struct packed {
        coord_t x_lo;
        coord_t x_hi;
        coord_t y_lo;
        coord_t y_hi;
    } rect_t;

    localparam int NUM_RECTS = 14;

    // Strokes of the word MENU, in screen pixels
    localparam rect_t RECTS [NUM_RECTS] = '{
        // M
        '{x_lo: 12'd170, x_hi: 12'd210, y_lo: 12'd90,  y_hi: 12'd250},
        '{x_lo: 12'd170, x_hi: 12'd370, y_lo: 12'd50,  y_hi: 12'd90},
        '{x_lo: 12'd250, x_hi: 12'd290, y_lo: 12'd90,  y_hi: 12'd250},
        '{x_lo: 12'd330, x_hi: 12'd370, y_lo: 12'd90,  y_hi: 12'd250},
        // E
        '{x_lo: 12'd420, x_hi: 12'd460, y_lo: 12'd50,  y_hi: 12'd250},
        '{x_lo: 12'd460, x_hi: 12'd500, y_lo: 12'd50,  y_hi: 12'd90},
        '{x_lo: 12'd460, x_hi: 12'd500, y_lo: 12'd130, y_hi: 12'd170},
        '{x_lo: 12'd460, x_hi: 12'd500, y_lo: 12'd210, y_hi: 12'd250},
        // N
        '{x_lo: 12'd550, x_hi: 12'd590, y_lo: 12'd90,  y_hi: 12'd250},
        '{x_lo: 12'd550, x_hi: 12'd670, y_lo: 12'd50,  y_hi: 12'd90},
        '{x_lo: 12'd630, x_hi: 12'd670, y_lo: 12'd90,  y_hi: 12'd250},
        // U
        '{x_lo: 12'd720, x_hi: 12'd760, y_lo: 12'd50,  y_hi: 12'd210},
        '{x_lo: 12'd720, x_hi: 12'd840, y_lo: 12'd210, y_hi: 12'd250},
        '{x_lo: 12'd800, x_hi: 12'd840, y_lo: 12'd50,  y_hi: 12'd210}
    };

    coord_t hcount;
    coord_t vcount;

    assign hcount = timing_in.hcount;
    assign vcount = timing_in.vcount;

    // OR over every stroke
    always_comb begin
        title_hit = 1'b0;
        for (int i = 0; i < NUM_RECTS; i++) begin
            if (hcount > RECTS[i].x_lo && hcount <= RECTS[i].x_hi &&
                vcount > RECTS[i].y_lo && vcount <= RECTS[i].y_hi) begin
                title_hit = 1'b1;
            end
        end
    end

endmodule

// File: arena_border_painter.sv
`timescale 1ns/1ps
`include "bg_settings.svh"

module arena_border_painter
    import bg_pkg::*;
(
    input  vga_timing_t timing_in,
    output logic        border_hit
);

    // Outer edges of the frame, low edge included, high edge excluded
    localparam coord_t OUTER_LEFT   = coord_t'(`BG_ARENA_LEFT - `BG_ARENA_BORDER);
    localparam coord_t OUTER_RIGHT  = coord_t'(`BG_ARENA_RIGHT + `BG_ARENA_BORDER);
    localparam coord_t OUTER_TOP    = coord_t'(`BG_ARENA_TOP - `BG_ARENA_BORDER);
    localparam coord_t OUTER_BOTTOM = coord_t'(`BG_ARENA_BOTTOM + `BG_ARENA_BORDER);

    localparam coord_t INNER_LEFT   = coord_t'(`BG_ARENA_LEFT);
    localparam coord_t INNER_RIGHT  = coord_t'(`BG_ARENA_RIGHT);
    localparam coord_t INNER_TOP    = coord_t'(`BG_ARENA_TOP);
    localparam coord_t INNER_BOTTOM = coord_t'(`BG_ARENA_BOTTOM);

    coord_t hcount;
    coord_t vcount;
    logic   left_strip;
    logic   right_strip;
    logic   top_strip;
    logic   bottom_strip;

    assign hcount = timing_in.hcount;
    assign vcount = timing_in.vcount;

    // Side strips run the full height including the corners
    assign left_strip = hcount >= OUTER_LEFT && hcount < INNER_LEFT &&
                        vcount >= OUTER_TOP && vcount < OUTER_BOTTOM;
    assign right_strip = hcount >= INNER_RIGHT && hcount < OUTER_RIGHT &&
                         vcount >= OUTER_TOP && vcount < OUTER_BOTTOM;

    // Top and bottom strips fill the gap between the sides
    assign top_strip = hcount >= INNER_LEFT && hcount < INNER_RIGHT &&
                       vcount >= OUTER_TOP && vcount < INNER_TOP;
    assign bottom_strip = hcount >= INNER_LEFT && hcount < INNER_RIGHT &&
                          vcount >= INNER_BOTTOM && vcount < OUTER_BOTTOM;

    assign border_hit = left_strip | right_strip | top_strip | bottom_strip;

endmodule

// File: pixel_mixer.sv
`timescale 1ns/1ps
`include "bg_settings.svh"

module pixel_mixer
    import bg_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  vga_timing_t timing_in,
    input  bg_mode_t    control_state,
    input  logic        edge_hit,
    input  logic        title_hit,
    input  logic        border_hit,
    input  rgb_t        edge_rgb,
    output vga_timing_t timing_out,
    output rgb_t        rgb_out
);

    rgb_t rgb_nxt;
    logic blank;
    logic mode_hit;

    assign blank = timing_in.hblnk | timing_in.vblnk;

    // Menu draws the title, game draws the arena frame
    always_comb begin
        case (control_state)
            MODE_MENU: mode_hit = title_hit;
            MODE_GAME: mode_hit = border_hit;
            default:   mode_hit = 1'b0;
        endcase
    end

    always_comb begin
        case (control_state)
            MODE_MENU, MODE_GAME: begin
                if (blank) begin
                    rgb_nxt = `BG_RGB_BLACK;
                end else if (edge_hit) begin
                    rgb_nxt = edge_rgb;
                end else if (mode_hit) begin
                    rgb_nxt = `BG_RGB_WHITE;
                end else begin
                    rgb_nxt = `BG_RGB_BLACK;
                end
            end
            default: begin
                // Screens not drawn here keep the last colour
                rgb_nxt = rgb_out;
            end
        endcase
    end

    // Single pipeline stage, timing passes through untouched
    always_ff @(posedge clk) begin
        if (rst) begin
            timing_out <= '0;
            rgb_out    <= '0;
        end else begin
            timing_out <= timing_in;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

// File: draw_background.sv
`timescale 1ns/1ps

module draw_background
    import bg_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  vga_timing_t timing_in,
    input  bg_mode_t    control_state,
    output vga_timing_t timing_out,
    output rgb_t        rgb_out
);

    logic edge_hit;
    rgb_t edge_rgb;
    logic title_hit;
    logic border_hit;

    // Painters look at the incoming pixel only
    screen_frame_painter frame0 (
        .timing_in (timing_in),
        .edge_hit  (edge_hit),
        .edge_rgb  (edge_rgb)
    );

    menu_title_painter title0 (
        .timing_in (timing_in),
        .title_hit (title_hit)
    );

    arena_border_painter border0 (
        .timing_in  (timing_in),
        .border_hit (border_hit)
    );

    // Colour selection and the output register
    pixel_mixer mixer0 (
        .clk           (clk),
        .rst           (rst),
        .timing_in     (timing_in),
        .control_state (control_state),
        .edge_hit      (edge_hit),
        .title_hit     (title_hit),
        .border_hit    (border_hit),
        .edge_rgb      (edge_rgb),
        .timing_out    (timing_out),
        .rgb_out       (rgb_out)
    );

endmodule

// File: tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

    // Columns: mode code, hcount, vcount, hblnk, vblnk, expected rgb_out
    // Mode 0 is the menu, 1 the game, 2 to 7 keep the previous colour

    typedef struct packed {
        logic [2:0]  mode;
        logic [11:0] hcount;
        logic [11:0] vcount;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vector_t;

    localparam logic [11:0] C_BLACK  = 12'h000;
    localparam logic [11:0] C_WHITE  = 12'hfff;
    localparam logic [11:0] C_YELLOW = 12'hff0;
    localparam logic [11:0] C_RED    = 12'hf00;
    localparam logic [11:0] C_GREEN  = 12'h0f0;
    localparam logic [11:0] C_BLUE   = 12'h00f;

    localparam int NUM_VECTORS = 41;

    localparam vector_t VECTORS [NUM_VECTORS] = '{
        // Screen edges, corners take the line colour
        '{3'd0, 12'd0,    12'd0,   1'b0, 1'b0, C_YELLOW},
        '{3'd0, 12'd500,  12'd0,   1'b0, 1'b0, C_YELLOW},
        '{3'd0, 12'd500,  12'd767, 1'b0, 1'b0, C_RED},
        '{3'd0, 12'd0,    12'd400, 1'b0, 1'b0, C_GREEN},
        '{3'd0, 12'd1023, 12'd400, 1'b0, 1'b0, C_BLUE},
        '{3'd1, 12'd1023, 12'd0,   1'b0, 1'b0, C_YELLOW},
        '{3'd1, 12'd0,    12'd767, 1'b0, 1'b0, C_RED},
        // Blanking beats everything
        '{3'd0, 12'd0,    12'd0,   1'b1, 1'b0, C_BLACK},
        '{3'd0, 12'd171,  12'd91,  1'b1, 1'b0, C_BLACK},
        '{3'd1, 12'd351,  12'd307, 1'b0, 1'b1, C_BLACK},
        '{3'd1, 12'd1023, 12'd400, 1'b1, 1'b1, C_BLACK},
        // Menu title strokes and their surroundings
        '{3'd0, 12'd171,  12'd91,  1'b0, 1'b0, C_WHITE},
        '{3'd0, 12'd370,  12'd250, 1'b0, 1'b0, C_WHITE},
        '{3'd0, 12'd170,  12'd91,  1'b0, 1'b0, C_BLACK},
        '{3'd0, 12'd171,  12'd50,  1'b0, 1'b0, C_BLACK},
        '{3'd0, 12'd211,  12'd100, 1'b0, 1'b0, C_BLACK},
        '{3'd0, 12'd480,  12'd150, 1'b0, 1'b0, C_WHITE},
        '{3'd0, 12'd650,  12'd60,  1'b0, 1'b0, C_WHITE},
        '{3'd0, 12'd840,  12'd230, 1'b0, 1'b0, C_WHITE},
        '{3'd0, 12'd780,  12'd150, 1'b0, 1'b0, C_BLACK},
        '{3'd0, 12'd351,  12'd307, 1'b0, 1'b0, C_BLACK},
        // Arena frame strips in the game
        '{3'd1, 12'd351,  12'd307, 1'b0, 1'b0, C_WHITE},
        '{3'd1, 12'd500,  12'd310, 1'b0, 1'b0, C_WHITE},
        '{3'd1, 12'd500,  12'd626, 1'b0, 1'b0, C_WHITE},
        '{3'd1, 12'd670,  12'd626, 1'b0, 1'b0, C_WHITE},
        '{3'd1, 12'd360,  12'd400, 1'b0, 1'b0, C_WHITE},
        '{3'd1, 12'd350,  12'd400, 1'b0, 1'b0, C_BLACK},
        '{3'd1, 12'd671,  12'd400, 1'b0, 1'b0, C_BLACK},
        '{3'd1, 12'd500,  12'd627, 1'b0, 1'b0, C_BLACK},
        '{3'd1, 12'd500,  12'd450, 1'b0, 1'b0, C_BLACK},
        '{3'd1, 12'd171,  12'd91,  1'b0, 1'b0, C_BLACK},
        // Unknown modes repeat the colour before them
        '{3'd0, 12'd0,    12'd0,   1'b0, 1'b0, C_YELLOW},
        '{3'd2, 12'd500,  12'd500, 1'b0, 1'b0, C_YELLOW},
        '{3'd3, 12'd171,  12'd91,  1'b1, 1'b0, C_YELLOW},
        '{3'd1, 12'd500,  12'd450, 1'b0, 1'b0, C_BLACK},
        '{3'd4, 12'd0,    12'd0,   1'b0, 1'b0, C_BLACK},
        '{3'd0, 12'd171,  12'd91,  1'b0, 1'b0, C_WHITE},
        '{3'd7, 12'd500,  12'd767, 1'b0, 1'b1, C_WHITE},
        '{3'd1, 12'd1023, 12'd400, 1'b0, 1'b0, C_BLUE},
        '{3'd5, 12'd500,  12'd450, 1'b0, 1'b0, C_BLUE},
        '{3'd6, 12'd0,    12'd0,   1'b1, 1'b1, C_BLUE}
    };

`endif

// File: tb_draw_background.sv
`timescale 1ns/1ps
`include "bg_settings.svh"

module tb_draw_background
    import bg_pkg::*;
();

    localparam int RESET_CYCLES = 4;
    localparam int NUM_RANDOM   = 200;
    localparam int SYNC_LIMIT   = 16;

    logic        clk;
    logic        rst;
    vga_timing_t timing_in;
    bg_mode_t    control_state;
    vga_timing_t timing_out;
    rgb_t        rgb_out;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'h48c6;

    `include "tb_vectors.svh"

    // Yellow top-line pixel held at the inputs while reset is active
    localparam vga_timing_t HIDDEN_PIXEL = '{vcount: 12'd0, vsync: 1'b0, vblnk: 1'b0,
                                             hcount: 12'd5, hsync: 1'b1, hblnk: 1'b0};

    // Fully blanked bottom-right pixel, easy to spot at the output
    localparam vga_timing_t MARKER_PIXEL = '{vcount: `BG_V_LAST, vsync: 1'b1, vblnk: 1'b1,
                                             hcount: `BG_H_LAST, hsync: 1'b1, hblnk: 1'b1};

    draw_background dut0 (
        .clk           (clk),
        .rst           (rst),
        .timing_in     (timing_in),
        .control_state (control_state),
        .timing_out    (timing_out),
        .rgb_out       (rgb_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper LCG bits for the counters, the low bits repeat quickly
    function automatic vga_timing_t random_timing();
        logic [31:0] r;
        vga_timing_t t;
        r = next_random();
        t.hcount = r[31:20];
        t.vcount = r[19:8];
        t.hsync  = r[7];
        t.vsync  = r[6];
        t.hblnk  = r[5];
        t.vblnk  = r[4];
        return t;
    endfunction

    function automatic vga_timing_t row_timing(input int idx);
        vga_timing_t t;
        t        = '0;
        t.hcount = VECTORS[idx].hcount;
        t.vcount = VECTORS[idx].vcount;
        t.hblnk  = VECTORS[idx].hblnk;
        t.vblnk  = VECTORS[idx].vblnk;
        return t;
    endfunction

    task automatic check_timing(input vga_timing_t expected, input string what);
        checks++;
        if (timing_out !== expected) begin
            errors++;
            $display("Error: timing_out = 0x%07h, expected 0x%07h (%s)",
                     timing_out, expected, what);
        end
    endtask

    task automatic check_rgb(input logic [11:0] expected, input string what);
        checks++;
        if (rgb_out !== expected) begin
            errors++;
            $display("Error: rgb_out = 0x%03h, expected 0x%03h (%s)", rgb_out, expected, what);
        end
    endtask

    // Reset drops on the last edge, so the final check covers the first cycle after it
    task automatic apply_reset();
        int i;
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            timing_in     <= HIDDEN_PIXEL;
            control_state <= MODE_MENU;
            @(negedge clk);
            check_timing('0, "reset");
            check_rgb(C_BLACK, "reset");
        end
    endtask

    task automatic check_pass_through();
        vga_timing_t prev;
        vga_timing_t cur;
        logic [31:0] r;
        int          i;
        prev = HIDDEN_PIXEL;
        for (i = 0; i < NUM_RANDOM; i++) begin
            @(posedge clk);
            cur           = random_timing();
            r             = next_random();
            timing_in     <= cur;
            control_state <= bg_mode_t'(r[31:29]);
            @(negedge clk);
            check_timing(prev, $sformatf("random pixel %0d", i));
            if (i == 0) begin
                check_rgb(C_YELLOW, "first pixel after reset");
            end
            prev = cur;
        end
    endtask

    task automatic wait_for_marker(output logic found);
        int n;
        found = 1'b0;
        n     = 0;
        while (!found && n < SYNC_LIMIT) begin
            @(posedge clk);
            timing_in     <= MARKER_PIXEL;
            control_state <= MODE_MENU;
            @(negedge clk);
            if (timing_out === MARKER_PIXEL) begin
                found = 1'b1;
            end
            n++;
        end
        if (found) begin
            check_rgb(C_BLACK, "blanked marker");
        end else begin
            errors++;
            $display("Timeout: marker pixel did not reach timing_out within %0d cycles",
                     SYNC_LIMIT);
        end
    endtask

    // Row i goes in while row i-1 is checked, one cycle of latency
    task automatic run_table();
        int i;
        for (i = 0; i <= NUM_VECTORS; i++) begin
            @(posedge clk);
            if (i < NUM_VECTORS) begin
                timing_in     <= row_timing(i);
                control_state <= bg_mode_t'(VECTORS[i].mode);
            end
            @(negedge clk);
            if (i > 0) begin
                check_timing(row_timing(i - 1), $sformatf("row %0d", i - 1));
                check_rgb(VECTORS[i - 1].rgb, $sformatf("row %0d", i - 1));
            end
        end
    endtask

    initial begin
        logic synced;
        rst           = 1'b1;
        timing_in     = '0;
        control_state = MODE_MENU;
        apply_reset();
        check_pass_through();
        wait_for_marker(synced);
        if (synced) begin
            run_table();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
bg_pkg.sv
screen_frame_painter.sv
menu_title_painter.sv
arena_border_painter.sv
pixel_mixer.sv
draw_background.sv
tb_draw_background.sv

// File: Makefile
# Verilator build and run for the background drawer

VERILATOR ?= verilator
TOP       ?= tb_draw_background
RTL_TOP   ?= draw_background
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Done: no errors

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -Mdir $(BUILD_DIR) \
		--top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
